//--- hw/fhe_params.svh
`ifndef FHE_PARAMS_SVH
`define FHE_PARAMS_SVH

// coefficient width in bits
`define FHE_FSIZE 16

// coefficients per buffer RAM word
`define FHE_E 4

// words per vector and matching address width
`define FHE_VEC_DEPTH 16
`define FHE_ADDR_W 4

// slots and module ports
// module port 0 is the host, 1 is vector op1, 2 is vector op2
`define FHE_SLOT_NUM 3
`define FHE_MODULE_NUM 3
`define FHE_IDX_W 2

`endif

//--- hw/fhe_data_pkg.sv
`include "fhe_params.svh"

package fhe_data_pkg;

    // one coefficient mod p
    typedef logic [`FHE_FSIZE-1:0] coeff_t;

    // one RAM word, lane l sits at bits [l*FSIZE +: FSIZE]
    typedef logic [`FHE_E*`FHE_FSIZE-1:0] lane_word_t;

    // word address inside a slot
    typedef logic [`FHE_ADDR_W-1:0] vec_addr_t;

endpackage

//--- hw/fhe_route_pkg.sv
`include "fhe_params.svh"

package fhe_route_pkg;

    typedef logic [`FHE_IDX_W-1:0] slot_idx_t;
    typedef logic [`FHE_IDX_W-1:0] module_idx_t;

    // element-wise operations of the vector unit
    typedef enum logic [1:0] {
        op_add        = 2'd0,
        op_sub        = 2'd1,
        op_add_scalar = 2'd2,
        op_sub_scalar = 2'd3
    } vector_op_t;

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_drain = 2'd2
    } vec_state_t;

endpackage

//--- hw/ram_port_if.sv
`timescale 1ns/100ps

interface ram_port_if
    import fhe_data_pkg::*;
();

    vec_addr_t  raddr;
    vec_addr_t  waddr;
    lane_word_t wdata;
    logic       wren;
    lane_word_t rdata;

    // module or crossbar side
    modport requester (
        output raddr, waddr, wdata, wren,
        input  rdata
    );

    modport memory (
        input  raddr, waddr, wdata, wren,
        output rdata
    );

endinterface

//--- hw/slot_bank.sv
`timescale 1ns/100ps
`include "fhe_params.svh"

module slot_bank
    import fhe_data_pkg::*;
(
    input logic        clk,
    ram_port_if.memory slot [`FHE_SLOT_NUM]
);

    // one simple dual-port RAM per slot
    for (genvar s = 0; s < `FHE_SLOT_NUM; s++) begin : g_slot
        lane_word_t mem [`FHE_VEC_DEPTH];

        always_ff @(posedge clk) begin
            if (slot[s].wren) begin
                mem[slot[s].waddr] <= slot[s].wdata;
            end
        end

        // registered read, old data on a same-address write
        always_ff @(posedge clk) begin
            slot[s].rdata <= mem[slot[s].raddr];
        end
    end

endmodule

//--- hw/buffer_interconnect.sv
`timescale 1ns/100ps
`include "fhe_params.svh"

module buffer_interconnect
    import fhe_data_pkg::*;
    import fhe_route_pkg::*;
(
    ram_port_if.memory    module_side [`FHE_MODULE_NUM],
    ram_port_if.requester slot_side [`FHE_SLOT_NUM],
    input  module_idx_t   module_select [`FHE_SLOT_NUM],
    input  slot_idx_t     slot_select [`FHE_MODULE_NUM]
);

    vec_addr_t  m_raddr [`FHE_MODULE_NUM];
    vec_addr_t  m_waddr [`FHE_MODULE_NUM];
    lane_word_t m_wdata [`FHE_MODULE_NUM];
    logic       m_wren  [`FHE_MODULE_NUM];
    lane_word_t s_rdata [`FHE_SLOT_NUM];

    // flatten interface arrays so they can be indexed at run time
    for (genvar m = 0; m < `FHE_MODULE_NUM; m++) begin : g_mod_in
        assign m_raddr[m] = module_side[m].raddr;
        assign m_waddr[m] = module_side[m].waddr;
        assign m_wdata[m] = module_side[m].wdata;
        assign m_wren[m]  = module_side[m].wren;
    end

    for (genvar s = 0; s < `FHE_SLOT_NUM; s++) begin : g_slot_in
        assign s_rdata[s] = slot_side[s].rdata;
    end

    // request path, module -> slot
    for (genvar s = 0; s < `FHE_SLOT_NUM; s++) begin : g_req
        logic hit;

        assign hit = (module_select[s] < `FHE_MODULE_NUM);

        assign slot_side[s].raddr = hit ? m_raddr[module_select[s]] : '0;
        assign slot_side[s].waddr = hit ? m_waddr[module_select[s]] : '0;
        assign slot_side[s].wdata = hit ? m_wdata[module_select[s]] : '0;
        assign slot_side[s].wren  = hit ? m_wren[module_select[s]] : 1'b0;
    end

    // read data path, slot -> module
    for (genvar m = 0; m < `FHE_MODULE_NUM; m++) begin : g_rsp
        logic hit;

        assign hit = (slot_select[m] < `FHE_SLOT_NUM);

        assign module_side[m].rdata = hit ? s_rdata[slot_select[m]] : '0;
    end

endmodule

//--- hw/vector_modular_unit.sv
`timescale 1ns/100ps
`include "fhe_params.svh"

module vector_modular_unit
    import fhe_data_pkg::*;
    import fhe_route_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          start,
    input  vector_op_t    operation,
    input  coeff_t        p,
    input  coeff_t        scalar,
    output logic          working,
    ram_port_if.requester op1,
    ram_port_if.requester op2
);

    vec_state_t state;
    vec_addr_t  rd_addr;
    vec_addr_t  wr_addr;
    logic       wr_valid;
    logic       last_rd;

    vector_op_t op_r;
    coeff_t     p_r;
    coeff_t     scalar_r;
    logic       is_sub;
    logic       use_scalar;
    lane_word_t result;

    // a +/- b mod m, both inputs already below m
    function automatic coeff_t mod_lane(
        input coeff_t a,
        input coeff_t b,
        input coeff_t m,
        input logic   sub
    );
        logic [`FHE_FSIZE:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sub) begin
            if (a >= b) begin
                return a - b;
            end
            // wraps mod 2^FSIZE, true value is below m
            return a + m - b;
        end
        if (sum >= {1'b0, m}) begin
            return coeff_t'(sum - {1'b0, m});
        end
        return sum[`FHE_FSIZE-1:0];
    endfunction

    assign last_rd = (rd_addr == vec_addr_t'(`FHE_VEC_DEPTH - 1));
    assign working = (state != st_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            rd_addr  <= '0;
            wr_valid <= 1'b0;
        end else begin
            // result of the word read this cycle is written next cycle
            wr_valid <= (state == st_run);
            case (state)
                st_idle: begin
                    if (start) begin
                        state   <= st_run;
                        rd_addr <= '0;
                    end
                end
                st_run: begin
                    rd_addr <= rd_addr + vec_addr_t'(1);
                    if (last_rd) begin
                        state <= st_drain;
                    end
                end
                st_drain: state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // operands captured on an accepted start
    always_ff @(posedge clk) begin
        wr_addr <= rd_addr;
        if (state == st_idle && start) begin
            op_r     <= operation;
            p_r      <= p;
            scalar_r <= scalar;
        end
    end

    assign is_sub     = (op_r == op_sub) || (op_r == op_sub_scalar);
    assign use_scalar = (op_r == op_add_scalar) || (op_r == op_sub_scalar);

    for (genvar l = 0; l < `FHE_E; l++) begin : g_lane
        coeff_t a;
        coeff_t b;

        assign a = op1.rdata[l*`FHE_FSIZE +: `FHE_FSIZE];
        assign b = use_scalar ? scalar_r : op2.rdata[l*`FHE_FSIZE +: `FHE_FSIZE];
        assign result[l*`FHE_FSIZE +: `FHE_FSIZE] = mod_lane(a, b, p_r, is_sub);
    end

    // results go back in place through op1
    assign op1.raddr = rd_addr;
    assign op1.waddr = wr_addr;
    assign op1.wdata = result;
    assign op1.wren  = wr_valid;

    // op2 is read only
    assign op2.raddr = rd_addr;
    assign op2.waddr = wr_addr;
    assign op2.wdata = '0;
    assign op2.wren  = 1'b0;

endmodule

//--- hw/module_set.sv
`timescale 1ns/100ps
`include "fhe_params.svh"

module module_set
    import fhe_data_pkg::*;
    import fhe_route_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    // host port
    input  vec_addr_t   host_raddr,
    input  vec_addr_t   host_waddr,
    input  lane_word_t  host_wdata,
    input  logic        host_wren,
    output lane_word_t  host_rdata,

    // routing
    input  module_idx_t module_select [`FHE_SLOT_NUM],
    input  slot_idx_t   slot_select [`FHE_MODULE_NUM],

    // vector unit
    input  logic        start,
    input  vector_op_t  operation,
    input  coeff_t      p,
    input  coeff_t      scalar,
    output logic        working
);

    // module ports: 0 host, 1 op1, 2 op2
    ram_port_if mod_port [`FHE_MODULE_NUM] ();
    ram_port_if slot_port [`FHE_SLOT_NUM] ();

    assign mod_port[0].raddr = host_raddr;
    assign mod_port[0].waddr = host_waddr;
    assign mod_port[0].wdata = host_wdata;
    assign mod_port[0].wren  = host_wren;
    assign host_rdata        = mod_port[0].rdata;

    slot_bank u_slot_bank (
        .clk  (clk),
        .slot (slot_port)
    );

    buffer_interconnect u_buffer_interconnect (
        .module_side   (mod_port),
        .slot_side     (slot_port),
        .module_select (module_select),
        .slot_select   (slot_select)
    );

    vector_modular_unit u_vector_modular_unit (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .operation (operation),
        .p         (p),
        .scalar    (scalar),
        .working   (working),
        .op1       (mod_port[1]),
        .op2       (mod_port[2])
    );

endmodule

//--- test/module_set_chk.sv
`timescale 1ns/100ps

module module_set_chk
    import fhe_route_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       start,
    input logic       working,
    input vec_state_t state,
    input logic       op1_wren,
    input logic       op2_wren
);

    a_idle_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        !working |-> !(op1_wren || op2_wren))
        else $error("vector unit writes while not working");

    a_op2_read_only: assert property (@(posedge clk) disable iff (!arst_n)
        !op2_wren)
        else $error("vector unit writes through op2");

    // start during the run phase must not end or restart the operation
    a_start_ignored: assert property (@(posedge clk) disable iff (!arst_n)
        (start && working && state == st_run) |=> working)
        else $error("start while working dropped working");

endmodule

bind vector_modular_unit module_set_chk u_module_set_chk (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (start),
    .working  (working),
    .state    (state),
    .op1_wren (op1.wren),
    .op2_wren (op2.wren)
);

//--- test/module_set_tb.sv
`timescale 1ns/100ps
`include "fhe_params.svh"

module module_set_tb
    import fhe_data_pkg::*;
    import fhe_route_pkg::*;
();

    // per phase cycle budgets for the timeout
    localparam int WR_CYC      = `FHE_VEC_DEPTH + 2;
    localparam int RD_CYC      = 2 * `FHE_VEC_DEPTH + 1;
    localparam int RUN_CYC     = `FHE_VEC_DEPTH + 4;
    localparam int OP_CYC      = 2 * WR_CYC + RUN_CYC + 2 * RD_CYC;
    localparam int TIMEOUT_CYC = 2 * (10 + 3 * (WR_CYC + RD_CYC) + 4 * OP_CYC);
    localparam int F           = `FHE_FSIZE;

    logic        clk;
    logic        arst_n;
    vec_addr_t   host_raddr;
    vec_addr_t   host_waddr;
    lane_word_t  host_wdata;
    logic        host_wren;
    lane_word_t  host_rdata;
    module_idx_t module_select [`FHE_SLOT_NUM];
    slot_idx_t   slot_select [`FHE_MODULE_NUM];
    logic        start;
    vector_op_t  operation;
    coeff_t      p;
    coeff_t      scalar;
    logic        working;

    lane_word_t  model [`FHE_SLOT_NUM][`FHE_VEC_DEPTH];
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;

    module_set u_module_set (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    function automatic lane_word_t rand_word(input int unsigned bound);
        lane_word_t w;
        for (int l = 0; l < `FHE_E; l++) begin
            w[l*F +: F] = coeff_t'($urandom % bound);
        end
        return w;
    endfunction

    // add wraps once at p and sub borrows p
    function automatic lane_word_t expected_word(input vector_op_t op, input lane_word_t x,
                                                 input lane_word_t y, input int unsigned pv,
                                                 input int unsigned sv);
        lane_word_t  r;
        int unsigned a;
        int unsigned b;
        for (int l = 0; l < `FHE_E; l++) begin
            a = x[l*F +: F];
            b = (op == op_add_scalar || op == op_sub_scalar) ? sv : y[l*F +: F];
            if (op == op_add || op == op_add_scalar) begin
                r[l*F +: F] = coeff_t'((a + b >= pv) ? a + b - pv : a + b);
            end else begin
                r[l*F +: F] = coeff_t'((a >= b) ? a - b : a + pv - b);
            end
        end
        return r;
    endfunction

    task automatic route_host(input int s);
        for (int i = 0; i < `FHE_SLOT_NUM; i++) begin
            module_select[i] <= (i == s) ? module_idx_t'(0) : module_idx_t'(3);
        end
        slot_select[0] <= slot_idx_t'(s);
    endtask

    task automatic load_slot(input int s, input int unsigned bound);
        lane_word_t w;
        for (int a = 0; a < `FHE_VEC_DEPTH; a++) begin
            w = rand_word(bound);
            model[s][a] = w;
            @(posedge clk);
            route_host(s);
            host_waddr <= vec_addr_t'(a);
            host_wdata <= w;
            host_wren  <= 1'b1;
        end
        @(posedge clk);
        host_wren <= 1'b0;
    endtask

    // data is due one cycle after the address
    task automatic read_back_slot(input int s);
        for (int a = 0; a < `FHE_VEC_DEPTH; a++) begin
            @(posedge clk);
            route_host(s);
            host_raddr <= vec_addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            check_value($sformatf("host_rdata slot %0d addr %0d", s, a), model[s][a],
                        host_rdata);
        end
    endtask

    task automatic run_vector_op(input vector_op_t op, input int op1_s, input int op2_s,
                                 input int unsigned pv, input int unsigned sv,
                                 input bit restart);
        int cyc;
        @(posedge clk);
        for (int i = 0; i < `FHE_SLOT_NUM; i++) begin
            module_select[i] <= module_idx_t'(3);
        end
        module_select[op1_s] <= module_idx_t'(1);
        module_select[op2_s] <= module_idx_t'(2);
        slot_select[1] <= slot_idx_t'(op1_s);
        slot_select[2] <= slot_idx_t'(op2_s);
        @(posedge clk);
        operation <= op;
        p         <= coeff_t'(pv);
        scalar    <= coeff_t'(sv);
        start     <= 1'b1;
        @(negedge clk);
        check_value("working before start", 64'(0), 64'(working));
        cyc = 0;
        do begin
            @(posedge clk);
            cyc++;
            start <= restart && cyc == 6;
            // operands after start must be ignored
            if (cyc == 1 || cyc == 6) begin
                operation <= vector_op_t'(2'($urandom));
                p         <= coeff_t'($urandom);
                scalar    <= coeff_t'($urandom);
            end
            @(negedge clk);
            if (cyc == 1) begin
                check_value("working after start", 64'(1), 64'(working));
            end
        end while (working && cyc < 2 * `FHE_VEC_DEPTH);
        check_value("working fall cycle", 64'(`FHE_VEC_DEPTH + 2), 64'(cyc));
        for (int a = 0; a < `FHE_VEC_DEPTH; a++) begin
            model[op1_s][a] = expected_word(op, model[op1_s][a], model[op2_s][a], pv, sv);
        end
    endtask

    initial begin
        int unsigned pv;
        int unsigned sv;
        void'($urandom(8));
        arst_n     = 1'b0;
        start      = 1'b0;
        operation  = op_add;
        p          = '0;
        scalar     = '0;
        host_raddr = '0;
        host_waddr = '0;
        host_wdata = '0;
        host_wren  = 1'b0;
        for (int i = 0; i < `FHE_SLOT_NUM; i++) begin
            module_select[i] = module_idx_t'(3);
        end
        for (int i = 0; i < `FHE_MODULE_NUM; i++) begin
            slot_select[i] = '0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("working after reset", 64'(0), 64'(working));

        for (int s = 0; s < `FHE_SLOT_NUM; s++) begin
            load_slot(s, 65536);
            read_back_slot(s);
        end

        pv = 2 + $urandom % 65534;
        load_slot(1, pv);
        load_slot(2, pv);
        run_vector_op(op_add, 1, 2, pv, 0, 1'b0);
        read_back_slot(1);
        read_back_slot(2);

        pv = 2 + $urandom % 65534;
        load_slot(2, pv);
        load_slot(0, pv);
        run_vector_op(op_sub, 2, 0, pv, 0, 1'b0);
        read_back_slot(2);
        read_back_slot(0);

        pv = 2 + $urandom % 65534;
        load_slot(0, pv);
        load_slot(1, pv);
        sv = $urandom % pv;
        run_vector_op(op_add_scalar, 0, 1, pv, sv, 1'b0);
        read_back_slot(0);
        sv = $urandom % pv;
        // second start lands mid-run here
        run_vector_op(op_sub_scalar, 0, 1, pv, sv, 1'b1);
        read_back_slot(0);
        read_back_slot(1);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+hw
hw/fhe_data_pkg.sv
hw/fhe_route_pkg.sv
hw/ram_port_if.sv
hw/slot_bank.sv
hw/buffer_interconnect.sv
hw/vector_modular_unit.sv
hw/module_set.sv
test/module_set_chk.sv
test/module_set_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module module_set_tb \
    -f flist.f -Mdir "$build_dir" -o module_set_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/module_set_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$log_file"; then
    exit 0
fi
exit 1
